// File: syscfg_pkg.sv
package syscfg_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int INDEX_WIDTH = ADDR_WIDTH - $clog2(STRB_WIDTH);

    localparam int NUM_MEMS    = 2;
    localparam int NUM_PERIPHS = 4;
    localparam int NUM_CORES   = 2;
    localparam int NUM_TGTS    = 8;

    localparam int TGT_IDX_WIDTH  = $clog2(NUM_TGTS);
    localparam int CORE_IDX_WIDTH = $clog2(NUM_CORES);

    // Target numbering: memories, then peripherals, then cores
    localparam int MEM_TGT0    = 0;
    localparam int PERIPH_TGT0 = 2;
    localparam int CORE_TGT0   = 6;

    // Word index bases of the three register regions
    localparam int MEM_BASE    = 'h100;
    localparam int PERIPH_BASE = 'h200;
    localparam int CORE_BASE   = 'h400;

    localparam int MEM_STRIDE    = 2;
    localparam int PERIPH_STRIDE = 2;
    localparam int CORE_STRIDE   = 4;
    localparam int SLOT_WIDTH    = $clog2(CORE_STRIDE);

    // Register slots inside one target block
    localparam int OFS_STATUS    = 0;
    localparam int OFS_MAESTRO   = 1;
    localparam int OFS_BOOT_ADDR = 2;
    localparam int OFS_IRQ_EN    = 3;

    localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR = '0;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [STRB_WIDTH-1:0]  strb_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_RESUME = 3'd1,
        CMD_PAUSE  = 3'd2,
        CMD_STOP   = 3'd3,
        CMD_RESET  = 3'd4
    } maestro_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAUSING,
        ST_RESUMING
    } maestro_state_e;

    typedef struct packed {
        addr_t paddr;
        logic  psel;
        logic  penable;
        logic  pwrite;
        data_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic   valid;
        logic   write;
        index_t index;
        data_t  wdata;
        data_t  mask;
    } reg_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } reg_rsp_t;

    typedef struct packed {
        logic srst;
        logic pause_req;
    } tgt_ctrl_t;

    typedef struct packed {
        logic paused;
        logic stopped;
    } tgt_status_t;

endpackage

// File: apb_slave_port.sv
`timescale 1ns/1ps

module apb_slave_port (
    input  logic                  seq,
    input  logic                  rst,
    input  syscfg_pkg::apb_req_t  apb_req,
    output syscfg_pkg::apb_rsp_t  apb_rsp,
    input  logic                  busy,
    output syscfg_pkg::reg_req_t  reg_req,
    input  syscfg_pkg::reg_rsp_t  reg_rsp
);

    import syscfg_pkg::*;

    logic  pready;
    logic  pslverr;
    data_t prdata;
    logic  pending;
    logic  finished;

    // A transfer is taken once, in the first cycle of psel
    assign pending  = apb_req.psel && !pready && !busy;
    assign finished = apb_req.psel && apb_req.penable && pready;

    always_comb begin
        reg_req.valid = pending;
        reg_req.write = apb_req.pwrite;
        reg_req.index = apb_req.paddr[ADDR_WIDTH-1:$clog2(STRB_WIDTH)];
        reg_req.wdata = apb_req.pwdata;
        // Byte strobes to bit mask
        for (int i = 0; i < STRB_WIDTH; i++) begin
            reg_req.mask[i*8 +: 8] = apb_req.pstrb[i] ? 8'hff : 8'h00;
        end
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else if (pending) begin
            pready  <= 1'b1;
            pslverr <= reg_rsp.err;
            prdata  <= apb_req.pwrite ? '0 : reg_rsp.rdata;
        end else if (finished) begin
            // Access phase done, back to idle
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end
    end

    always_comb begin
        apb_rsp.prdata  = prdata;
        apb_rsp.pready  = pready;
        apb_rsp.pslverr = pslverr;
    end

endmodule

// File: target_maestro.sv
`timescale 1ns/1ps

module target_maestro (
    input  logic                      seq,
    input  logic                      rst,
    input  syscfg_pkg::maestro_cmd_e  cmd,
    output logic                      done,
    input  logic                      pause_ack,
    output syscfg_pkg::tgt_ctrl_t     ctrl,
    output syscfg_pkg::tgt_status_t   status
);

    import syscfg_pkg::*;

    maestro_state_e state_q;
    logic           srst_q;
    logic           pause_req_q;
    logic           paused_q;
    logic           stopped_q;
    logic           known_cmd;

    assign known_cmd = (cmd == CMD_RESUME) || (cmd == CMD_PAUSE) ||
                       (cmd == CMD_STOP) || (cmd == CMD_RESET);

    always_comb begin
        done = 1'b0;
        case (state_q)
            ST_IDLE:     done = (cmd != CMD_NONE) && !known_cmd;
            // Reset falls through to the resume phase instead
            ST_PAUSING:  done = pause_ack && (cmd != CMD_RESET);
            ST_RESUMING: done = !pause_req_q && !pause_ack;
            default:     done = 1'b0;
        endcase
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            srst_q      <= 1'b1;
            pause_req_q <= 1'b0;
            paused_q    <= 1'b0;
            stopped_q   <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cmd == CMD_RESUME) begin
                        srst_q      <= 1'b0;
                        pause_req_q <= 1'b0;
                        state_q     <= ST_RESUMING;
                    end else if (cmd == CMD_PAUSE || cmd == CMD_STOP || cmd == CMD_RESET) begin
                        pause_req_q <= 1'b1;
                        state_q     <= ST_PAUSING;
                    end
                end
                ST_PAUSING: begin
                    if (pause_ack) begin
                        paused_q <= 1'b1;
                        if (cmd != CMD_PAUSE) begin
                            srst_q    <= 1'b1;
                            stopped_q <= 1'b1;
                        end
                        state_q <= (cmd == CMD_RESET) ? ST_RESUMING : ST_IDLE;
                    end
                end
                ST_RESUMING: begin
                    // srst held at least one cycle after a reset
                    srst_q      <= 1'b0;
                    pause_req_q <= 1'b0;
                    if (done) begin
                        paused_q  <= 1'b0;
                        stopped_q <= 1'b0;
                        state_q   <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ctrl.srst      = srst_q;
        ctrl.pause_req = pause_req_q;
        status.paused  = paused_q;
        status.stopped = stopped_q;
    end

endmodule

// File: syscfg_regs.sv
`timescale 1ns/1ps

module syscfg_regs (
    input  logic                      seq,
    input  logic                      rst,
    input  syscfg_pkg::reg_req_t      reg_req,
    output syscfg_pkg::reg_rsp_t      reg_rsp,
    output logic                      busy,
    output syscfg_pkg::maestro_cmd_e  cmd [syscfg_pkg::NUM_TGTS],
    input  logic [syscfg_pkg::NUM_TGTS-1:0]    done,
    input  syscfg_pkg::tgt_status_t   status [syscfg_pkg::NUM_TGTS],
    input  logic [syscfg_pkg::NUM_PERIPHS-1:0] periph_irq,
    output syscfg_pkg::addr_t         core_boot_addr [syscfg_pkg::NUM_CORES],
    output logic [syscfg_pkg::NUM_CORES-1:0]   core_irq
);

    import syscfg_pkg::*;

    maestro_cmd_e cmd_q [NUM_TGTS];
    addr_t        boot_addr_q [NUM_CORES];
    data_t        irq_en_q [NUM_CORES];
    logic         bootstrap_q;

    // Decoded request
    index_t                    idx;
    index_t                    rel;
    logic                      hit;
    logic [TGT_IDX_WIDTH-1:0]  tgt;
    logic [CORE_IDX_WIDTH-1:0] core;
    logic [SLOT_WIDTH-1:0]     slot;

    logic wr;
    logic maestro_wr;
    logic boot_wr;
    logic irq_wr;

    assign idx = reg_req.index;

    always_comb begin
        hit  = 1'b0;
        rel  = '0;
        tgt  = '0;
        core = '0;
        slot = '0;
        if (idx >= MEM_BASE && idx < MEM_BASE + NUM_MEMS * MEM_STRIDE) begin
            hit  = 1'b1;
            rel  = idx - index_t'(MEM_BASE);
            tgt  = TGT_IDX_WIDTH'(rel / MEM_STRIDE + MEM_TGT0);
            slot = SLOT_WIDTH'(rel % MEM_STRIDE);
        end else if (idx >= PERIPH_BASE && idx < PERIPH_BASE + NUM_PERIPHS * PERIPH_STRIDE) begin
            hit  = 1'b1;
            rel  = idx - index_t'(PERIPH_BASE);
            tgt  = TGT_IDX_WIDTH'(rel / PERIPH_STRIDE + PERIPH_TGT0);
            slot = SLOT_WIDTH'(rel % PERIPH_STRIDE);
        end else if (idx >= CORE_BASE && idx < CORE_BASE + NUM_CORES * CORE_STRIDE) begin
            hit  = 1'b1;
            rel  = idx - index_t'(CORE_BASE);
            core = CORE_IDX_WIDTH'(rel / CORE_STRIDE);
            tgt  = TGT_IDX_WIDTH'(rel / CORE_STRIDE + CORE_TGT0);
            slot = SLOT_WIDTH'(rel % CORE_STRIDE);
        end
    end

    // Read data and error, same cycle as the request
    always_comb begin
        reg_rsp.rdata = '0;
        reg_rsp.err   = 1'b0;
        if (!hit) begin
            reg_rsp.err = 1'b1;
        end else begin
            case (slot)
                SLOT_WIDTH'(OFS_STATUS): begin
                    reg_rsp.rdata[0] = status[tgt].paused;
                    reg_rsp.rdata[1] = status[tgt].stopped;
                    reg_rsp.err      = reg_req.write;
                end
                SLOT_WIDTH'(OFS_MAESTRO): begin
                    reg_rsp.rdata = DATA_WIDTH'(cmd_q[tgt]);
                    reg_rsp.err   = reg_req.write && (cmd_q[tgt] != CMD_NONE);
                end
                SLOT_WIDTH'(OFS_BOOT_ADDR): begin
                    reg_rsp.rdata = boot_addr_q[core];
                end
                default: begin
                    reg_rsp.rdata = irq_en_q[core];
                end
            endcase
        end
    end

    assign wr         = reg_req.valid && reg_req.write && !reg_rsp.err;
    assign maestro_wr = wr && (slot == SLOT_WIDTH'(OFS_MAESTRO));
    assign boot_wr    = wr && (slot == SLOT_WIDTH'(OFS_BOOT_ADDR));
    assign irq_wr     = wr && (slot == SLOT_WIDTH'(OFS_IRQ_EN));

    always_ff @(posedge seq) begin
        if (rst) begin
            for (int t = 0; t < NUM_TGTS; t++) begin
                cmd_q[t] <= CMD_NONE;
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                boot_addr_q[c] <= BOOT_ADDR;
                irq_en_q[c]    <= '0;
            end
            bootstrap_q <= 1'b1;
        end else begin
            for (int t = 0; t < NUM_TGTS; t++) begin
                if (done[t]) begin
                    cmd_q[t] <= CMD_NONE;
                end
            end
            if (bootstrap_q) begin
                // Start memory 0, then core 0, one at a time
                if (cmd_q[MEM_TGT0] == CMD_NONE && cmd_q[CORE_TGT0] == CMD_NONE) begin
                    if (status[MEM_TGT0].stopped) begin
                        cmd_q[MEM_TGT0] <= CMD_RESUME;
                    end else if (status[CORE_TGT0].stopped) begin
                        cmd_q[CORE_TGT0] <= CMD_RESUME;
                    end else begin
                        bootstrap_q <= 1'b0;
                    end
                end
            end else if (maestro_wr) begin
                cmd_q[tgt] <= maestro_cmd_e'(reg_req.wdata[2:0] & reg_req.mask[2:0]);
            end
            if (boot_wr) begin
                boot_addr_q[core] <= (reg_req.wdata & reg_req.mask) |
                                     (boot_addr_q[core] & ~reg_req.mask);
            end
            if (irq_wr) begin
                irq_en_q[core] <= (reg_req.wdata & reg_req.mask) |
                                  (irq_en_q[core] & ~reg_req.mask);
            end
        end
    end

    assign busy = bootstrap_q;
    assign cmd  = cmd_q;

    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            core_boot_addr[c] = boot_addr_q[c];
            core_irq[c]       = 1'b0;
            for (int p = 0; p < NUM_PERIPHS; p++) begin
                core_irq[c] = core_irq[c] | (irq_en_q[c][p] & periph_irq[p]);
            end
        end
    end

endmodule

// File: syscfg_top.sv
`timescale 1ns/1ps

module syscfg_top (
    input  logic                               seq,
    input  logic                               rst,
    input  syscfg_pkg::apb_req_t               apb_req,
    output syscfg_pkg::apb_rsp_t               apb_rsp,
    input  logic [syscfg_pkg::NUM_TGTS-1:0]    tgt_pause_ack,
    output syscfg_pkg::tgt_ctrl_t              tgt_ctrl [syscfg_pkg::NUM_TGTS],
    input  logic [syscfg_pkg::NUM_PERIPHS-1:0] periph_irq,
    output syscfg_pkg::addr_t                  core_boot_addr [syscfg_pkg::NUM_CORES],
    output logic [syscfg_pkg::NUM_CORES-1:0]   core_irq
);

    import syscfg_pkg::*;

    reg_req_t            reg_req;
    reg_rsp_t            reg_rsp;
    logic                busy;
    maestro_cmd_e        cmd [NUM_TGTS];
    logic [NUM_TGTS-1:0] done;
    tgt_status_t         status [NUM_TGTS];

    apb_slave_port i_apb_slave_port (
        .seq     (seq),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .busy    (busy),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp)
    );

    syscfg_regs i_syscfg_regs (
        .seq            (seq),
        .rst            (rst),
        .reg_req        (reg_req),
        .reg_rsp        (reg_rsp),
        .busy           (busy),
        .cmd            (cmd),
        .done           (done),
        .status         (status),
        .periph_irq     (periph_irq),
        .core_boot_addr (core_boot_addr),
        .core_irq       (core_irq)
    );

    // One sequencer per target
    for (genvar t = 0; t < NUM_TGTS; t++) begin : g_maestro
        target_maestro i_target_maestro (
            .seq       (seq),
            .rst       (rst),
            .cmd       (cmd[t]),
            .done      (done[t]),
            .pause_ack (tgt_pause_ack[t]),
            .ctrl      (tgt_ctrl[t]),
            .status    (status[t])
        );
    end

endmodule

// File: syscfg_asserts.sv
`timescale 1ns/1ps

module syscfg_asserts (
    input logic                               seq,
    input logic                               rst,
    input syscfg_pkg::apb_req_t               apb_req,
    input syscfg_pkg::apb_rsp_t               apb_rsp,
    input syscfg_pkg::tgt_ctrl_t              tgt_ctrl [syscfg_pkg::NUM_TGTS],
    input logic [syscfg_pkg::NUM_CORES-1:0]   core_irq
);

    import syscfg_pkg::*;

    logic [NUM_TGTS-1:0] pause_reqs;
    int                  fail_count = 0;

    always_comb begin
        for (int t = 0; t < NUM_TGTS; t++) begin
            pause_reqs[t] = tgt_ctrl[t].pause_req;
        end
    end

    a_err_with_ready: assert property (@(posedge seq) disable iff (rst)
        apb_rsp.pslverr |-> apb_rsp.pready)
    else begin
        fail_count++;
        $error("pslverr high without pready");
    end

    // Zero wait states, so ready drops right after the access phase
    a_ready_falls: assert property (@(posedge seq) disable iff (rst)
        (apb_req.psel && apb_req.penable && apb_rsp.pready) |=> !apb_rsp.pready)
    else begin
        fail_count++;
        $error("pready still high after a completed access");
    end

    a_quiet_in_reset: assert property (@(posedge seq)
        rst |=> (pause_reqs == '0 && core_irq == '0))
    else begin
        fail_count++;
        $error("pause_req or core_irq high during reset");
    end

endmodule

bind syscfg_top syscfg_asserts i_syscfg_asserts (
    .seq      (seq),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .tgt_ctrl (tgt_ctrl),
    .core_irq (core_irq)
);

// File: tb_syscfg.sv
`timescale 1ns/1ps

module tb_syscfg;

    import syscfg_pkg::*;

    localparam int TIMEOUT = 200;

    logic                   seq = 1'b0;
    logic                   rst;
    apb_req_t               apb_req;
    apb_rsp_t               apb_rsp;
    logic [NUM_TGTS-1:0]    tgt_pause_ack = '0;
    tgt_ctrl_t              tgt_ctrl [NUM_TGTS];
    logic [NUM_PERIPHS-1:0] periph_irq;
    addr_t                  core_boot_addr [NUM_CORES];
    logic [NUM_CORES-1:0]   core_irq;

    integer              seed = 32'h7921_3b4e;
    integer              ack_seed = 32'h7921_3b4e;
    int                  errors = 0;
    int                  checks = 0;
    logic [NUM_TGTS-1:0] hold = '0;
    int                  ack_delay [NUM_TGTS];

    // Expected target and core register state
    logic [NUM_TGTS-1:0] exp_paused;
    logic [NUM_TGTS-1:0] exp_stopped;
    logic [NUM_TGTS-1:0] exp_srst;
    logic [NUM_TGTS-1:0] exp_pause_req;
    data_t               exp_boot [NUM_CORES];
    data_t               exp_irq_en [NUM_CORES];

    syscfg_top i_syscfg_top (.*);

    always #2 seq = ~seq;

    // Targets follow pause_req after 0 to 3 cycles unless held
    always @(negedge seq) begin
        for (int t = 0; t < NUM_TGTS; t++) begin
            if (rst) begin
                tgt_pause_ack[t] = 1'b0;
                ack_delay[t]     = 0;
            end else if (!hold[t] && tgt_pause_ack[t] != tgt_ctrl[t].pause_req) begin
                if (ack_delay[t] == 0) begin
                    tgt_pause_ack[t] = tgt_ctrl[t].pause_req;
                    ack_delay[t]     = $unsigned($random(ack_seed)) % 4;
                end else begin
                    ack_delay[t] = ack_delay[t] - 1;
                end
            end
        end
    end

    task automatic report_and_finish();
        errors = errors + i_syscfg_top.i_syscfg_asserts.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("Run stopped: %s", why);
        report_and_finish();
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic index_t reg_index(input int t, input int ofs);
        if (t < PERIPH_TGT0) begin
            return index_t'(MEM_BASE + (t - MEM_TGT0) * MEM_STRIDE + ofs);
        end else if (t < CORE_TGT0) begin
            return index_t'(PERIPH_BASE + (t - PERIPH_TGT0) * PERIPH_STRIDE + ofs);
        end
        return index_t'(CORE_BASE + (t - CORE_TGT0) * CORE_STRIDE + ofs);
    endfunction

    function automatic logic is_mapped(input index_t idx);
        return (idx >= MEM_BASE && idx < MEM_BASE + NUM_MEMS * MEM_STRIDE) ||
               (idx >= PERIPH_BASE && idx < PERIPH_BASE + NUM_PERIPHS * PERIPH_STRIDE) ||
               (idx >= CORE_BASE && idx < CORE_BASE + NUM_CORES * CORE_STRIDE);
    endfunction

    function automatic data_t strb_mask(input strb_t strb);
        data_t m;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            m[i*8 +: 8] = {8{strb[i]}};
        end
        return m;
    endfunction

    // Setup phase, then access phase until pready
    task automatic apb_xfer(input index_t idx, input logic write, input data_t wdata,
                            input strb_t strb, output data_t rdata, output logic err);
        int n;
        apb_req.paddr   = {idx, 2'b00};
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(negedge seq);
        apb_req.penable = 1'b1;
        n = 0;
        while (!apb_rsp.pready && n < TIMEOUT) begin
            @(negedge seq);
            n++;
        end
        if (!apb_rsp.pready) begin
            abort_run($sformatf("APB transfer to index %h never got pready", idx));
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(negedge seq);
            apb_req.psel    = 1'b0;
            apb_req.penable = 1'b0;
        end
    endtask

    function automatic void apply_cmd(input int t, input int code);
        case (code)
            CMD_RESUME, CMD_RESET: begin
                exp_srst[t]      = 1'b0;
                exp_pause_req[t] = 1'b0;
                exp_paused[t]    = 1'b0;
                exp_stopped[t]   = 1'b0;
            end
            CMD_PAUSE: begin
                exp_pause_req[t] = 1'b1;
                exp_paused[t]    = 1'b1;
            end
            CMD_STOP: begin
                exp_pause_req[t] = 1'b1;
                exp_paused[t]    = 1'b1;
                exp_srst[t]      = 1'b1;
                exp_stopped[t]   = 1'b1;
            end
            default: begin
            end
        endcase
    endfunction

    // Poll the maestro register until it clears
    task automatic wait_cmd_done(input int t, input int code);
        data_t rd;
        logic  err;
        int    n;
        n = 0;
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b0, '0, '0, rd, err);
        while (rd != '0 && n < TIMEOUT) begin
            apb_xfer(reg_index(t, OFS_MAESTRO), 1'b0, '0, '0, rd, err);
            n++;
        end
        if (rd != '0) begin
            abort_run($sformatf("command %0d on target %0d never completed", code, t));
        end else begin
            apply_cmd(t, code);
        end
    endtask

    task automatic check_target(input string test, input int t);
        data_t rd;
        logic  err;
        apb_xfer(reg_index(t, OFS_STATUS), 1'b0, '0, '0, rd, err);
        check_value($sformatf("%s status err t%0d", test, t), '0, data_t'(err));
        check_value($sformatf("%s status t%0d", test, t),
                    data_t'({exp_stopped[t], exp_paused[t]}), rd);
        check_value($sformatf("%s srst t%0d", test, t),
                    data_t'(exp_srst[t]), data_t'(tgt_ctrl[t].srst));
        check_value($sformatf("%s pause_req t%0d", test, t),
                    data_t'(exp_pause_req[t]), data_t'(tgt_ctrl[t].pause_req));
    endtask

    initial begin
        data_t  rd;
        data_t  wd;
        data_t  expv;
        logic   err;
        strb_t  strb;
        int     t;
        int     c;
        int     ofs;
        index_t idx;

        rst        = 1'b1;
        apb_req    = '0;
        periph_irq = '0;
        repeat (3) @(posedge seq);
        @(negedge seq);
        rst = 1'b0;

        // Bootstrap leaves memory 0 and core 0 running
        exp_paused    = '0;
        exp_pause_req = '0;
        exp_stopped   = '1;
        exp_srst      = '1;
        exp_stopped[MEM_TGT0]  = 1'b0;
        exp_srst[MEM_TGT0]     = 1'b0;
        exp_stopped[CORE_TGT0] = 1'b0;
        exp_srst[CORE_TGT0]    = 1'b0;
        for (int i = 0; i < NUM_CORES; i++) begin
            exp_boot[i]   = BOOT_ADDR;
            exp_irq_en[i] = '0;
        end
        for (int i = 0; i < NUM_TGTS; i++) begin
            check_target("bootstrap", i);
        end

        for (int i = 0; i < 24; i++) begin
            c    = $unsigned($random(seed)) % NUM_CORES;
            ofs  = ($random(seed) & 1) ? OFS_BOOT_ADDR : OFS_IRQ_EN;
            wd   = $random(seed);
            strb = $random(seed);
            expv = (ofs == OFS_BOOT_ADDR) ? exp_boot[c] : exp_irq_en[c];
            expv = (wd & strb_mask(strb)) | (expv & ~strb_mask(strb));
            if (ofs == OFS_BOOT_ADDR) begin
                exp_boot[c] = expv;
            end else begin
                exp_irq_en[c] = expv;
            end
            apb_xfer(reg_index(CORE_TGT0 + c, ofs), 1'b1, wd, strb, rd, err);
            check_value($sformatf("core reg write err c%0d", c), '0, data_t'(err));
            check_value($sformatf("boot addr pins c%0d", c), exp_boot[c], core_boot_addr[c]);
            apb_xfer(reg_index(CORE_TGT0 + c, ofs), 1'b0, '0, '0, rd, err);
            check_value($sformatf("core reg readback c%0d ofs %0d", c, ofs), expv, rd);
        end

        for (int i = 0; i < NUM_TGTS; i++) begin
            apb_xfer(reg_index(i, OFS_STATUS), 1'b1, $random(seed), 4'hf, rd, err);
            check_value($sformatf("status write err t%0d", i), 1, data_t'(err));
        end

        // Indices around each region, plus some far away
        for (int i = 0; i < 40; i++) begin
            case ($unsigned($random(seed)) % 4)
                0:       idx = index_t'(MEM_BASE);
                1:       idx = index_t'(PERIPH_BASE);
                2:       idx = index_t'(CORE_BASE);
                default: idx = index_t'($random(seed));
            endcase
            idx = idx - 8 + index_t'($unsigned($random(seed)) % 16);
            if (is_mapped(idx)) begin
                apb_xfer(idx, 1'b0, '0, '0, rd, err);
                check_value($sformatf("mapped read err %h", idx), '0, data_t'(err));
            end else begin
                apb_xfer(idx, 1'b1, $random(seed), 4'hf, rd, err);
                check_value($sformatf("unmapped write err %h", idx), 1, data_t'(err));
            end
        end

        for (int i = 0; i < 60; i++) begin
            t  = $unsigned($random(seed)) % NUM_TGTS;
            wd = $unsigned($random(seed)) % 8;
            apb_xfer(reg_index(t, OFS_MAESTRO), 1'b1, wd, 4'hf, rd, err);
            check_value($sformatf("cmd write err t%0d", t), '0, data_t'(err));
            wait_cmd_done(t, int'(wd));
            for (int u = 0; u < NUM_TGTS; u++) begin
                check_target($sformatf("cmd %0d", wd), u);
            end
        end

        // Pause held pending by a frozen target
        t  = PERIPH_TGT0 + $unsigned($random(seed)) % NUM_PERIPHS;
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b1, CMD_RESUME, 4'hf, rd, err);
        wait_cmd_done(t, CMD_RESUME);
        hold[t] = 1'b1;
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b1, CMD_PAUSE, 4'hf, rd, err);
        check_value("busy first write err", '0, data_t'(err));
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b0, '0, '0, rd, err);
        check_value("busy pending cmd", CMD_PAUSE, rd);
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b1, CMD_RESUME, 4'hf, rd, err);
        check_value("busy second write err", 1, data_t'(err));
        apb_xfer(reg_index(t, OFS_MAESTRO), 1'b0, '0, '0, rd, err);
        check_value("busy cmd kept", CMD_PAUSE, rd);
        hold[t] = 1'b0;
        wait_cmd_done(t, CMD_PAUSE);
        check_target("busy", t);

        for (int i = 0; i < 20; i++) begin
            for (int k = 0; k < NUM_CORES; k++) begin
                exp_irq_en[k] = $random(seed);
                apb_xfer(reg_index(CORE_TGT0 + k, OFS_IRQ_EN), 1'b1, exp_irq_en[k], 4'hf,
                         rd, err);
            end
            periph_irq = $random(seed);
            @(negedge seq);
            for (int k = 0; k < NUM_CORES; k++) begin
                check_value($sformatf("irq route c%0d", k),
                            data_t'(|(exp_irq_en[k][NUM_PERIPHS-1:0] & periph_irq)),
                            data_t'(core_irq[k]));
            end
        end

        report_and_finish();
    end

endmodule

// File: sim.f
syscfg_pkg.sv
apb_slave_port.sv
target_maestro.sv
syscfg_regs.sv
syscfg_top.sv
syscfg_asserts.sv
tb_syscfg.sv

// File: Makefile
TOP = tb_syscfg

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module syscfg_top syscfg_pkg.sv apb_slave_port.sv \
		target_maestro.sv syscfg_regs.sv syscfg_top.sv

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
